// File: common/tcb_bus_pkg.sv
package tcb_bus_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // address width, counts words not bytes
  localparam int unsigned ABW = 16;

  // data width
  localparam int unsigned DBW = 32;

  // one enable per byte lane
  localparam int unsigned BEW = DBW / 8;

  //////////////////////////////////////////////////
  // timing
  //////////////////////////////////////////////////

  // cycles from transfer to response
  localparam int unsigned DLY = 1;

  //////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////

  typedef logic [ABW-1:0] adr_t;
  typedef logic [DBW-1:0] dat_t;
  typedef logic [BEW-1:0] ben_t;

endpackage : tcb_bus_pkg

// File: common/tcb_arb_pkg.sv
package tcb_arb_pkg;

  // largest supported port count
  localparam int unsigned PN_MAX = 8;

  // grant behaviour for the coming cycle
  // open: grant may move, held: locked sequence keeps it
  typedef enum logic {
    ARB_OPEN = 1'b0,
    ARB_HELD = 1'b1
  } arb_st_t;

  // width of the port index, never below one bit
  function automatic int unsigned idx_w(input int unsigned pn);
    return (pn > 1) ? $clog2(pn) : 1;
  endfunction

endpackage : tcb_arb_pkg

// File: tcb_mux/tcb_arbiter.sv
`timescale 1ns/100ps

module tcb_arbiter #(
  // number of manager ports
  parameter  int unsigned PN = 4,
  // port index width
  localparam int unsigned PL = tcb_arb_pkg::idx_w(PN)
)(
  // clock and reset
  input  logic          man,
  input  logic          rst_n,
  // request state of every port
  input  logic [PN-1:0] prt_vld,
  input  logic [PN-1:0] prt_lck,
  // memory side transfer strobe
  input  logic          trn,
  // granted port
  output logic [PL-1:0] sel
);

  import tcb_arb_pkg::*;

  //////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////

  if ((PN < 2) || (PN > PN_MAX)) begin : g_pn_chk
    $error("tcb_arbiter: PN = %0d outside 2..%0d", PN, PN_MAX);
  end

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // hold or release decision
  arb_st_t       arb_st;
  // next requester in round-robin order
  logic [PL-1:0] nxt;

  //////////////////////////////////////////////////
  // lock decision
  //////////////////////////////////////////////////

  // locked transfer on the granted port keeps the grant
  assign arb_st = (trn && prt_lck[sel]) ? ARB_HELD : ARB_OPEN;

  //////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////

  // search upward from sel+1, wrapping around
  // last step lands on sel itself, so a lone requester stays granted
  always_comb begin
    int unsigned idx;
    logic        hit;
    nxt = sel;
    hit = 1'b0;
    idx = 0;
    for (int unsigned k = 1; k <= PN; k++) begin
      idx = (int'(sel) + k) % PN;
      // first requester wins
      if (!hit && prt_vld[idx]) begin
        nxt = PL'(idx);
        hit = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // grant register
  //////////////////////////////////////////////////

  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      sel <= '0;
    end else begin
      case (arb_st)
        // locked sequence continues
        ARB_HELD: sel <= sel;
        // nxt equals sel when nobody asks
        default:  sel <= nxt;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // a locked transfer pins the grant for the next cycle
  a_lck_hold: assert property (
    @(posedge man) disable iff (!rst_n)
    (trn && prt_lck[sel]) |=> $stable(sel)
  ) else $error("tcb_arbiter: grant moved after a locked transfer");

endmodule : tcb_arbiter

// File: tcb_mux/tcb_lib_mux.sv
`timescale 1ns/100ps

module tcb_lib_mux #(
  // number of manager ports
  parameter  int unsigned PN = 4,
  // port index width
  localparam int unsigned PL = tcb_arb_pkg::idx_w(PN)
)(
  // clock and reset
  input  logic                         man,
  input  logic                         rst_n,
  // granted port from the arbiter
  input  logic [PL-1:0]                sel,
  // port side requests
  input  logic [PN-1:0]                prt_vld,
  input  logic [PN-1:0]                prt_wen,
  input  tcb_bus_pkg::adr_t [PN-1:0]   prt_adr,
  input  tcb_bus_pkg::ben_t [PN-1:0]   prt_ben,
  input  tcb_bus_pkg::dat_t [PN-1:0]   prt_wdt,
  // port side responses
  output logic [PN-1:0]                prt_rdy,
  output tcb_bus_pkg::dat_t [PN-1:0]   prt_rdt,
  output logic [PN-1:0]                prt_err,
  // memory side request
  output logic                         mem_vld,
  output logic                         mem_wen,
  output tcb_bus_pkg::adr_t            mem_adr,
  output tcb_bus_pkg::ben_t            mem_ben,
  output tcb_bus_pkg::dat_t            mem_wdt,
  // memory side response
  input  logic                         mem_rdy,
  input  tcb_bus_pkg::dat_t            mem_rdt,
  input  logic                         mem_err,
  // transfer strobe back to the arbiter
  output logic                         trn
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // port that owns the response in flight
  logic [PL-1:0] rsp_sel;

  //////////////////////////////////////////////////
  // request steering
  //////////////////////////////////////////////////

  // zero cycles from sel to memory side
  assign mem_vld = prt_vld[sel];
  assign mem_wen = prt_wen[sel];
  assign mem_adr = prt_adr[sel];
  assign mem_ben = prt_ben[sel];
  assign mem_wdt = prt_wdt[sel];

  // handshake on the memory side
  assign trn = mem_vld & mem_rdy;

  //////////////////////////////////////////////////
  // response select
  //////////////////////////////////////////////////

  // captured per transfer, response follows one cycle later
  // a new request may already be steered meanwhile
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      rsp_sel <= '0;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  //////////////////////////////////////////////////
  // per port outputs
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : g_prt
    // ready only toward the granted port
    assign prt_rdy[i] = (sel == PL'(i)) ? mem_rdy : 1'b0;
    // response phase, other ports read zero
    assign prt_rdt[i] = (rsp_sel == PL'(i)) ? mem_rdt : '0;
    assign prt_err[i] = (rsp_sel == PL'(i)) ? mem_err : 1'b0;
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // arbiter must never point past the last port
  a_sel_rng: assert property (
    @(posedge man) disable iff (!rst_n)
    sel < PL'(PN - 1) || sel == PL'(PN - 1)
  ) else $error("tcb_lib_mux: select %0d beyond port count %0d", sel, PN);

endmodule : tcb_lib_mux

// File: verilog/tcb_mem.sv
`timescale 1ns/100ps

module tcb_mem #(
  // number of memory words
  parameter int unsigned DEPTH = 64
)(
  // clock and reset
  input  logic              man,
  input  logic              rst_n,
  // request
  input  logic              mem_vld,
  input  logic              mem_wen,
  input  tcb_bus_pkg::adr_t mem_adr,
  input  tcb_bus_pkg::ben_t mem_ben,
  input  tcb_bus_pkg::dat_t mem_wdt,
  // response
  output logic              mem_rdy,
  output tcb_bus_pkg::dat_t mem_rdt,
  output logic              mem_err
);

  import tcb_bus_pkg::*;

  // word index width
  localparam int unsigned MW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  //////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////

  // response path below is a single register stage
  if (DLY != 1) begin : g_dly_chk
    $error("tcb_mem: response delay %0d not supported", DLY);
  end

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // word storage
  dat_t          mem [0:DEPTH-1];
  // handshake
  logic          trn;
  // address inside the array
  logic          in_rng;
  logic [MW-1:0] idx;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // ready rises on the first edge after reset, then stays
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      mem_rdy <= 1'b0;
    end else begin
      mem_rdy <= 1'b1;
    end
  end

  assign trn = mem_vld & mem_rdy;

  // address counts words
  assign in_rng = (32'(mem_adr) < DEPTH);
  assign idx    = mem_adr[MW-1:0];

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // only enabled lanes change, out of range writes dropped
  always_ff @(posedge man) begin
    if (trn && mem_wen && in_rng) begin
      for (int unsigned b = 0; b < BEW; b++) begin
        if (mem_ben[b]) begin
          mem[idx][8*b +: 8] <= mem_wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // error flag, one cycle after the transfer
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      mem_err <= 1'b0;
    end else begin
      mem_err <= trn & ~in_rng;
    end
  end

  // whole word read, zero for a bad address
  always_ff @(posedge man) begin
    if (trn) begin
      mem_rdt <= in_rng ? mem[idx] : '0;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // unknown valid would corrupt both array and grant
  a_vld_known: assert property (
    @(posedge man) disable iff (!rst_n)
    !$isunknown(mem_vld)
  ) else $error("tcb_mem: request valid is unknown");

endmodule : tcb_mem

// File: verilog/tcb_mux_top.sv
`timescale 1ns/100ps

module tcb_mux_top #(
  // number of manager ports
  parameter  int unsigned PN    = 4,
  // number of memory words
  parameter  int unsigned DEPTH = 64,
  // port index width
  localparam int unsigned PL    = tcb_arb_pkg::idx_w(PN)
)(
  // clock and reset
  input  logic                       man,
  input  logic                       rst_n,
  // manager port requests
  input  logic [PN-1:0]              prt_vld,
  input  logic [PN-1:0]              prt_wen,
  input  tcb_bus_pkg::adr_t [PN-1:0] prt_adr,
  input  tcb_bus_pkg::ben_t [PN-1:0] prt_ben,
  input  tcb_bus_pkg::dat_t [PN-1:0] prt_wdt,
  input  logic [PN-1:0]              prt_lck,
  // manager port responses
  output logic [PN-1:0]              prt_rdy,
  output tcb_bus_pkg::dat_t [PN-1:0] prt_rdt,
  output logic [PN-1:0]              prt_err
);

  import tcb_bus_pkg::*;

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // arbiter and multiplexer
  logic [PL-1:0] sel;
  logic          trn;

  // memory side request
  logic          mem_vld;
  logic          mem_wen;
  adr_t          mem_adr;
  ben_t          mem_ben;
  dat_t          mem_wdt;
  // memory side response
  logic          mem_rdy;
  dat_t          mem_rdt;
  logic          mem_err;

  //////////////////////////////////////////////////
  // arbiter
  //////////////////////////////////////////////////

  tcb_arbiter #(
    .PN      (PN)
  ) u_arb (
    .man     (man),
    .rst_n   (rst_n),
    .prt_vld (prt_vld),
    .prt_lck (prt_lck),
    .trn     (trn),
    .sel     (sel)
  );

  //////////////////////////////////////////////////
  // multiplexer
  //////////////////////////////////////////////////

  tcb_lib_mux #(
    .PN      (PN)
  ) u_mux (
    .man     (man),
    .rst_n   (rst_n),
    .sel     (sel),
    .prt_vld (prt_vld),
    .prt_wen (prt_wen),
    .prt_adr (prt_adr),
    .prt_ben (prt_ben),
    .prt_wdt (prt_wdt),
    .prt_rdy (prt_rdy),
    .prt_rdt (prt_rdt),
    .prt_err (prt_err),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_err (mem_err),
    .trn     (trn)
  );

  //////////////////////////////////////////////////
  // memory subordinate
  //////////////////////////////////////////////////

  tcb_mem #(
    .DEPTH   (DEPTH)
  ) u_mem (
    .man     (man),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_err (mem_err)
  );

endmodule : tcb_mux_top

// File: test/tcb_mux_tb.sv
`timescale 1ns/100ps

module tcb_mux_tb;

  import tcb_bus_pkg::*;

  //////////////////////////////////////////////////
  // test parameters
  //////////////////////////////////////////////////

  localparam int unsigned PN     = 4;
  localparam int unsigned DEPTH  = 64;
  // requests per port in the random and lock phases
  localparam int unsigned N_RND  = 24;
  localparam int unsigned N_LCK  = 4;
  localparam int unsigned N_OTH  = 4;
  localparam int unsigned MAXR   = 32;
  // all requests of all phases
  localparam int unsigned N_REQ  = DEPTH + PN*N_RND + (N_LCK + 2) + (PN - 1)*N_OTH;
  // watchdog limit in clock cycles
  localparam int unsigned WD_CYC = N_REQ*PN*4 + 100;

  typedef struct packed {
    logic lck;
    logic wen;
    ben_t ben;
    adr_t adr;
    dat_t wdt;
  } req_t;

  typedef struct packed {
    logic dat;
    logic err;
    dat_t rdt;
  } rsp_t;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic              man;
  logic              rst_n = 1'b1;
  logic [PN-1:0]     prt_vld;
  logic [PN-1:0]     prt_wen;
  logic [PN-1:0]     prt_lck;
  adr_t [PN-1:0]     prt_adr;
  ben_t [PN-1:0]     prt_ben;
  dat_t [PN-1:0]     prt_wdt;
  logic [PN-1:0]     prt_rdy;
  dat_t [PN-1:0]     prt_rdt;
  logic [PN-1:0]     prt_err;

  // monitor state updated on the falling edge
  logic [PN-1:0]     xfer;
  logic [PN-1:0]     rsp_chk;
  logic [PN-1:0]     rsp_dat;
  logic [PN-1:0]     rsp_err;
  dat_t              rsp_rdt [PN];
  logic              rr_pend;
  logic              rr_chk;
  logic [PN-1:0]     rr_pend_exp;
  logic [PN-1:0]     rr_exp;
  int                wait_cnt [PN];
  logic              settle;
  // reference memory and expected responses
  dat_t              ref_mem [DEPTH];
  rsp_t              exp_q [PN][$];
  // request lists per port
  req_t              req_lst [PN][MAXR];
  int                req_n [PN];
  int                req_i [PN];
  int                seed;
  int                val_err;
  int                prot_err;

  tcb_mux_top #(
    .PN      (PN),
    .DEPTH   (DEPTH)
  ) dut (
    .man     (man),
    .rst_n   (rst_n),
    .prt_vld (prt_vld),
    .prt_wen (prt_wen),
    .prt_adr (prt_adr),
    .prt_ben (prt_ben),
    .prt_wdt (prt_wdt),
    .prt_lck (prt_lck),
    .prt_rdy (prt_rdy),
    .prt_rdt (prt_rdt),
    .prt_err (prt_err)
  );

  // 4 ns period
  always #2 man = ~man;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [PN-1:0] port_bit(input int p);
    logic [PN-1:0] m;
    m    = '0;
    m[p] = 1'b1;
    return m;
  endfunction

  // first requester above cur with wrap around
  // cur itself comes last
  function automatic int next_requester(input int cur, input logic [PN-1:0] vld);
    int idx;
    for (int k = 1; k <= PN; k++) begin
      idx = (cur + k) % PN;
      if (vld[idx]) return idx;
    end
    return cur;
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    val_err++;
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic protocol_error(input string what);
    prot_err++;
    $display("protocol error: %s", what);
  endtask

  task automatic add_req(input int p, input logic lck, input logic wen, input ben_t ben,
                         input adr_t adr, input dat_t wdt);
    req_lst[p][req_n[p]] = {lck, wen, ben, adr, wdt};
    req_n[p]++;
  endtask

  task automatic clear_lists();
    for (int p = 0; p < PN; p++) begin
      req_n[p] = 0;
      req_i[p] = 0;
    end
  endtask

  // drive the port's current request or go idle
  task automatic present(input int p);
    req_t r;
    if (req_i[p] < req_n[p]) begin
      r          = req_lst[p][req_i[p]];
      prt_vld[p] = 1'b1;
      prt_lck[p] = r.lck;
      prt_wen[p] = r.wen;
      prt_ben[p] = r.ben;
      prt_adr[p] = r.adr;
      prt_wdt[p] = r.wdt;
    end else begin
      prt_vld[p] = 1'b0;
      prt_lck[p] = 1'b0;
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic run_phase();
    logic busy;
    for (int p = 0; p < PN; p++) present(p);
    do begin
      @(posedge man);
      #1;
      // xfer holds the transfers of the edge just passed
      for (int p = 0; p < PN; p++) begin
        if (xfer[p]) begin
          req_i[p]++;
          present(p);
        end
      end
      busy = |prt_vld;
    end while (busy);
    // last response retires
    repeat (2) @(posedge man);
    #1;
  endtask

  // reference model with byte lanes applied
  task automatic model_transfer(input int p);
    rsp_t             r;
    logic [$clog2(DEPTH)-1:0] wi;
    r.dat = ~prt_wen[p];
    wi    = prt_adr[p][$clog2(DEPTH)-1:0];
    if (32'(prt_adr[p]) >= DEPTH) begin
      r.err = 1'b1;
      r.dat = 1'b1;
      r.rdt = '0;
    end else begin
      r.err = 1'b0;
      r.rdt = ref_mem[wi];
      if (prt_wen[p]) begin
        for (int b = 0; b < BEW; b++) begin
          if (prt_ben[p][b]) ref_mem[wi][8*b +: 8] = prt_wdt[p][8*b +: 8];
        end
      end
    end
    exp_q[p].push_back(r);
  endtask

  //////////////////////////////////////////////////
  // monitor
  //////////////////////////////////////////////////

  // mid cycle when all DUT signals have settled
  always @(negedge man) begin
    rsp_t r;
    if (!rst_n) begin
      xfer        = '0;
      rsp_chk     = '0;
      rsp_dat     = '0;
      rsp_err     = '0;
      rr_pend     = 1'b0;
      rr_chk      = 1'b0;
      rr_pend_exp = '0;
      rr_exp      = '0;
      for (int p = 0; p < PN; p++) begin
        rsp_rdt[p]  = '0;
        wait_cnt[p] = 0;
      end
    end else begin
      // responses of last edge's transfers are on the bus now
      for (int p = 0; p < PN; p++) begin
        rsp_chk[p] = 1'b0;
        if (xfer[p]) begin
          r          = exp_q[p].pop_front();
          rsp_chk[p] = 1'b1;
          rsp_dat[p] = r.dat;
          rsp_err[p] = r.err;
          rsp_rdt[p] = r.rdt;
        end
      end
      // grant expected in the cycle now running
      rr_chk  = rr_pend;
      rr_exp  = rr_pend_exp;
      rr_pend = 1'b0;
      // transfers at the coming edge
      xfer = prt_vld & prt_rdy;
      for (int p = 0; p < PN; p++) begin
        if (xfer[p]) begin
          model_transfer(p);
          if (!prt_lck[p] && ((prt_vld & ~port_bit(p)) != '0)) begin
            rr_pend     = 1'b1;
            rr_pend_exp = port_bit(next_requester(p, prt_vld));
          end
        end
      end
      // transfers by others while a port waits
      // a locked transfer restarts the count
      for (int p = 0; p < PN; p++) begin
        if (!prt_vld[p] || xfer[p] || ((xfer & prt_lck) != '0)) begin
          wait_cnt[p] = 0;
        end else if (xfer != '0) begin
          wait_cnt[p]++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_one_rdy: assert property (@(posedge man) disable iff (!rst_n) $onehot0(prt_rdy))
    else protocol_error("more than one port ready in one cycle");

  a_rr: assert property (@(posedge man) disable iff (!rst_n) rr_chk |-> (prt_rdy == rr_exp))
    else value_error("rr_grant", 32'(rr_exp), 32'($sampled(prt_rdy)));

  // only port 0 may see ready around reset
  a_rst: assert property (@(posedge man)
    (!rst_n || settle) |-> ((prt_err == '0) && ((prt_rdy & ~port_bit(0)) == '0)))
    else protocol_error("error flag or foreign ready seen around reset");

  for (genvar p = 0; p < PN; p++) begin : g_chk
    a_rdt: assert property (@(posedge man) disable iff (!rst_n)
      (rsp_chk[p] && rsp_dat[p]) |-> (prt_rdt[p] == rsp_rdt[p]))
      else value_error($sformatf("rd_data port %0d", p), rsp_rdt[p], $sampled(prt_rdt[p]));

    a_err: assert property (@(posedge man) disable iff (!rst_n)
      rsp_chk[p] |-> (prt_err[p] == rsp_err[p]))
      else value_error($sformatf("rsp_err port %0d", p), 32'(rsp_err[p]),
                       32'($sampled(prt_err[p])));

    a_b2b: assert property (@(posedge man) disable iff (!rst_n)
      (prt_rdy[p] && !(prt_vld[p] && prt_lck[p]) && ((prt_vld & ~port_bit(p)) != '0))
      |=> !prt_rdy[p])
      else protocol_error($sformatf("port %0d ready twice while another port waits", p));

    a_fair: assert property (@(posedge man) disable iff (!rst_n) wait_cnt[p] < PN)
      else protocol_error($sformatf("port %0d waited through %0d transfers", p, PN));

    a_lck: assert property (@(posedge man) disable iff (!rst_n)
      (prt_vld[p] && prt_rdy[p] && prt_lck[p]) |=> ((prt_rdy & ~port_bit(p)) == '0))
      else protocol_error($sformatf("grant left port %0d during a lock", p));
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [31:0] rnd3;
    seed     = 11;
    val_err  = 0;
    prot_err = 0;
    man      = 1'b0;
    settle   = 1'b0;
    prt_vld  = '0;
    prt_wen  = '0;
    prt_lck  = '0;
    prt_adr  = '0;
    prt_ben  = '0;
    prt_wdt  = '0;
    rst_n    = 1'b0;
    repeat (2) @(posedge man);
    #1;
    rst_n  = 1'b1;
    settle = 1'b1;
    repeat (2) @(posedge man);
    #1;
    settle = 1'b0;

    // fill every word with ports interleaved
    clear_lists();
    for (int k = 0; k < DEPTH; k++) begin
      rnd = $random(seed);
      add_req(k % PN, 1'b0, 1'b1, '1, adr_t'(k), rnd);
    end
    run_phase();

    // random mix with some addresses beyond DEPTH
    clear_lists();
    for (int p = 0; p < PN; p++) begin
      for (int k = 0; k < N_RND; k++) begin
        rnd  = $random(seed);
        rnd2 = $random(seed);
        rnd3 = $random(seed);
        add_req(p, 1'b0, rnd[31], rnd[BEW-1:0], adr_t'(rnd2 % (DEPTH + 8)), rnd3);
      end
    end
    run_phase();

    // port 1 locks while the rest keep reading
    clear_lists();
    for (int k = 0; k < N_LCK + 2; k++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      rnd3 = $random(seed);
      add_req(1, (k < N_LCK), rnd[31], rnd[BEW-1:0], adr_t'(rnd2 % DEPTH), rnd3);
    end
    for (int p = 0; p < PN; p++) begin
      for (int k = 0; k < N_OTH; k++) begin
        rnd2 = $random(seed);
        if (p != 1) add_req(p, 1'b0, 1'b0, '0, adr_t'(rnd2 % DEPTH), '0);
      end
    end
    run_phase();

    $display("summary: %0d value errors, %0d protocol errors", val_err, prot_err);
    if (val_err == 0 && prot_err == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // upper bound from the request count
  initial begin
    #(WD_CYC * 4);
    $display("watchdog expired after %0d cycles, traffic did not drain", WD_CYC);
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tcb_mux_tb

// File: tcb_mux.f
common/tcb_bus_pkg.sv
common/tcb_arb_pkg.sv
tcb_mux/tcb_arbiter.sv
tcb_mux/tcb_lib_mux.sv
verilog/tcb_mem.sv
verilog/tcb_mux_top.sv
test/tcb_mux_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tcb_mux_tb \
  -f tcb_mux.f \
  -o tcb_mux_sim

out=$(./obj_dir/tcb_mux_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
